// ==== uart_config.svh ====
// UART peripheral configuration
// widths, FIFO depth, register offsets and register reset values
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`define UART_DW       8                             // byte width
`define UART_FIFO_SZ  16                            // FIFO depth, power of two
`define UART_AW       ($clog2(`UART_FIFO_SZ))       // FIFO pointer width
`define UART_CW       ($clog2(`UART_FIFO_SZ + 1))   // FIFO load count width
`define UART_RW       16                            // baud counter width

// register offsets
`define UART_REG_TX_DAT  6'h00
`define UART_REG_TX_CNT  6'h04
`define UART_REG_TX_BDR  6'h08
`define UART_REG_TX_IRQ  6'h10
`define UART_REG_RX_DAT  6'h20
`define UART_REG_RX_CNT  6'h24
`define UART_REG_RX_BDR  6'h28
`define UART_REG_RX_SMP  6'h2C
`define UART_REG_RX_IRQ  6'h30

// reset values
`define UART_BDR_RST  16'd15   // 16 cycles per bit
`define UART_SMP_RST  16'd7    // mid bit
`define UART_IRQ_RST  5'd0     // both irq levels

`endif

// ==== tcb_pkg.sv ====
// TCB register bus package
// bus operation and payload types
package tcb_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bus operation
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    TCB_RD = 1'b0,  // read, data on rdt
    TCB_WR = 1'b1   // write, data on wdt
  } tcb_op_t;

  //////////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////////

  // byte address, only the low 6 bits are decoded
  typedef logic [6-1:0] tcb_adr_t;

  // data word
  typedef logic [32-1:0] tcb_dat_t;

endpackage

// ==== uart_pkg.sv ====
// UART package
// register map and ser/des FSM states
`include "uart_config.svh"

package uart_pkg;

  // register offsets on the TCB bus
  typedef enum logic [6-1:0] {
    REG_TX_DAT = `UART_REG_TX_DAT,  // push TX FIFO, write only
    REG_TX_CNT = `UART_REG_TX_CNT,  // TX FIFO load, read only
    REG_TX_BDR = `UART_REG_TX_BDR,  // TX baud
    REG_TX_IRQ = `UART_REG_TX_IRQ,  // TX irq level
    REG_RX_DAT = `UART_REG_RX_DAT,  // pop RX FIFO, read only
    REG_RX_CNT = `UART_REG_RX_CNT,  // RX FIFO load, read only
    REG_RX_BDR = `UART_REG_RX_BDR,  // RX baud
    REG_RX_SMP = `UART_REG_RX_SMP,  // RX sample phase
    REG_RX_IRQ = `UART_REG_RX_IRQ   // RX irq level
  } uart_reg_t;

  // serializer states
  typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_t;

  // deserializer states
  typedef enum logic [1:0] {DES_IDLE, DES_START, DES_DATA, DES_STOP} des_state_t;

endpackage

// ==== tcb_if.sv ====
// TCB register bus interface
// single master, transfer on vld & rdy, same cycle read data
interface tcb_if
  import tcb_pkg::*;
(
  input logic tcb,    // bus clock
  input logic rst_n   // sync reset, active low
);

  logic     vld;  // request valid
  tcb_op_t  op;   // read or write
  tcb_adr_t adr;  // byte address
  tcb_dat_t wdt;  // write data
  tcb_dat_t rdt;  // read data, combinational
  logic     rdy;  // ready, low means stall

  modport man (input tcb, rst_n, rdt, rdy, output vld, op, adr, wdt);
  modport sub (input tcb, rst_n, vld, op, adr, wdt, output rdt, rdy);

endinterface

// ==== uart_fifo.sv ====
// UART byte FIFO
// circular buffer with valid/ready on both sides and a load count
`include "uart_config.svh"

module uart_fifo (
  input  logic                  tcb,
  input  logic                  rst_n,
  // stream in
  input  logic                  sti_vld,
  input  logic [`UART_DW-1:0]   sti_dat,
  output logic                  sti_rdy,
  // stream out
  output logic                  sto_vld,
  output logic [`UART_DW-1:0]   sto_dat,
  input  logic                  sto_rdy,
  // status
  output logic [`UART_CW-1:0]   cnt
);

  logic [`UART_DW-1:0] mem [0:`UART_FIFO_SZ-1];
  logic [`UART_AW-1:0] wr_ptr, rd_ptr;  // wrap on their own, depth is 2**n
  logic                push, pop;

  assign sti_rdy = (cnt != `UART_FIFO_SZ);  // not full
  assign sto_vld = (cnt != 0);             // not empty
  assign sto_dat = mem[rd_ptr];

  assign push = sti_vld & sti_rdy;
  assign pop  = sto_vld & sto_rdy;

  // storage
  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

  // pointers and load
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // idle, or push and pop together
      endcase
    end
  end

endmodule

// ==== uart_ser.sv ====
// UART TX serializer
// start bit, 8 data bits LSB first, one stop bit; each bit cfg_bdr+1 cycles
`include "uart_config.svh"

module uart_ser
  import uart_pkg::*;
(
  input  logic                tcb,
  input  logic                rst_n,
  input  logic [`UART_RW-1:0] cfg_bdr,  // cycles per bit minus one
  // byte stream
  input  logic                str_vld,
  input  logic [`UART_DW-1:0] str_dat,
  output logic                str_rdy,
  // serial line
  output logic                txd
);

  ser_state_t                    state;
  logic [`UART_RW-1:0]           cnt;  // cycle within bit
  logic [$clog2(`UART_DW)-1:0]   idx;  // data bit index
  logic [`UART_DW-1:0]           shr;  // shift register
  logic                          bit_end;

  assign str_rdy = (state == SER_IDLE);  // one byte at a time
  assign bit_end = (cnt == cfg_bdr);

  // shifter, next bit always in shr[0]
  always_ff @(posedge tcb) begin
    if (str_vld && str_rdy) begin
      shr <= str_dat;
    end else if (bit_end && (state == SER_START || state == SER_DATA)) begin
      shr <= shr >> 1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state <= SER_IDLE;
      cnt   <= '0;
      idx   <= '0;
      txd   <= 1'b1;  // line idles high
    end else begin
      case (state)
        SER_IDLE: if (str_vld) begin
          txd   <= 1'b0;  // start bit
          cnt   <= '0;
          state <= SER_START;
        end
        SER_START: if (bit_end) begin
          txd   <= shr[0];  // bit 0
          cnt   <= '0;
          idx   <= '0;
          state <= SER_DATA;
        end else cnt <= cnt + 1'b1;
        SER_DATA: if (bit_end) begin
          cnt <= '0;
          if (idx == (`UART_DW - 1)) begin
            txd   <= 1'b1;  // stop bit
            state <= SER_STOP;
          end else begin
            txd <= shr[0];
            idx <= idx + 1'b1;
          end
        end else cnt <= cnt + 1'b1;
        SER_STOP: if (bit_end) begin
          cnt   <= '0;
          state <= SER_IDLE;  // txd stays high
        end else cnt <= cnt + 1'b1;
        default: state <= SER_IDLE;
      endcase
    end
  end

endmodule

// ==== uart_des.sv ====
// UART RX deserializer
// start edge detect, one sample per bit at cfg_smp, byte out at mid stop bit
`include "uart_config.svh"

module uart_des
  import uart_pkg::*;
(
  input  logic                tcb,
  input  logic                rst_n,
  input  logic [`UART_RW-1:0] cfg_bdr,  // cycles per bit minus one
  input  logic [`UART_RW-1:0] cfg_smp,  // sample cycle within bit
  input  logic                rxd,      // async serial line
  // byte stream, no back-pressure
  output logic                str_vld,
  output logic [`UART_DW-1:0] str_dat
);

  logic [1:0]                    rxd_sync;  // two flop synchronizer
  logic                          rxd_s, rxd_d;
  logic                          fall;
  des_state_t                    state;
  logic [`UART_RW-1:0]           cnt;
  logic [$clog2(`UART_DW)-1:0]   idx;
  logic [`UART_DW-1:0]           shr;
  logic                          smp_hit, bit_end;

  //////////////////////////////////////////////////////////////////////////
  // line input
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rxd_sync <= 2'b11;  // idle high
      rxd_d    <= 1'b1;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_d    <= rxd_s;
    end
  end

  assign rxd_s   = rxd_sync[1];
  assign fall    = rxd_d & ~rxd_s;
  assign smp_hit = (cnt == cfg_smp);
  assign bit_end = (cnt == cfg_bdr);

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state   <= DES_IDLE;
      cnt     <= '0;
      idx     <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= 1'b0;  // single cycle pulse
      case (state)
        DES_IDLE: if (fall) begin
          cnt   <= '0;
          state <= DES_START;
        end
        DES_START: if (smp_hit && rxd_s) begin
          cnt   <= '0;  // glitch, not a start bit
          state <= DES_IDLE;
        end else if (bit_end) begin
          cnt   <= '0;
          idx   <= '0;
          state <= DES_DATA;
        end else cnt <= cnt + 1'b1;
        DES_DATA: if (bit_end) begin
          cnt <= '0;
          if (idx == (`UART_DW - 1)) state <= DES_STOP;
          else idx <= idx + 1'b1;
        end else cnt <= cnt + 1'b1;
        DES_STOP: if (smp_hit) begin
          str_vld <= 1'b1;
          cnt     <= '0;
          state   <= DES_IDLE;  // rearm for the next start edge
        end else cnt <= cnt + 1'b1;
        default: state <= DES_IDLE;
      endcase
    end
  end

  // data capture, LSB arrives first
  always_ff @(posedge tcb) begin
    if (state == DES_DATA && smp_hit) shr <= {rxd_s, shr[`UART_DW-1:1]};
    if (state == DES_STOP && smp_hit) str_dat <= shr;
  end

endmodule

// ==== uart_regs.sv ====
// UART register block
// TCB decode, config registers, FIFO push/pop and interrupt levels
`include "uart_config.svh"

module uart_regs
  import tcb_pkg::*, uart_pkg::*;
(
  tcb_if.sub                  bus,
  // TX FIFO in
  output logic                tx_vld,
  output logic [`UART_DW-1:0] tx_dat,
  input  logic                tx_rdy,
  // RX FIFO out
  input  logic                rx_vld,
  input  logic [`UART_DW-1:0] rx_dat,
  output logic                rx_rdy,
  // FIFO loads
  input  logic [`UART_CW-1:0] tx_cnt,
  input  logic [`UART_CW-1:0] rx_cnt,
  // config
  output logic [`UART_RW-1:0] tx_bdr,
  output logic [`UART_RW-1:0] rx_bdr,
  output logic [`UART_RW-1:0] rx_smp,
  // interrupts
  output logic                irq_tx,
  output logic                irq_rx
);

  uart_reg_t           reg_adr;
  logic                trn, wr, rd;
  logic [`UART_CW-1:0] tx_irq, rx_irq;  // irq levels

  assign reg_adr = uart_reg_t'(bus.adr);
  assign wr      = bus.vld & (bus.op == TCB_WR);
  assign rd      = bus.vld & (bus.op == TCB_RD);

  // stall only a TX data write into a full FIFO
  assign bus.rdy = ~(wr && (reg_adr == REG_TX_DAT) && !tx_rdy);
  assign trn     = bus.vld & bus.rdy;

  //////////////////////////////////////////////////////////////////////////
  // FIFO access
  //////////////////////////////////////////////////////////////////////////

  assign tx_vld = wr && (reg_adr == REG_TX_DAT);  // held by master until rdy
  assign tx_dat = bus.wdt[`UART_DW-1:0];
  assign rx_rdy = trn && rd && (reg_adr == REG_RX_DAT);  // pop on read

  //////////////////////////////////////////////////////////////////////////
  // read mux
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_adr)
      REG_TX_CNT: bus.rdt = tcb_dat_t'(tx_cnt);
      REG_TX_BDR: bus.rdt = tcb_dat_t'(tx_bdr);
      REG_TX_IRQ: bus.rdt = tcb_dat_t'(tx_irq);
      REG_RX_DAT: bus.rdt = rx_vld ? tcb_dat_t'(rx_dat) : '0;  // empty reads zero
      REG_RX_CNT: bus.rdt = tcb_dat_t'(rx_cnt);
      REG_RX_BDR: bus.rdt = tcb_dat_t'(rx_bdr);
      REG_RX_SMP: bus.rdt = tcb_dat_t'(rx_smp);
      REG_RX_IRQ: bus.rdt = tcb_dat_t'(rx_irq);
      default:    bus.rdt = '0;  // TX data and unused offsets
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // config writes
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus.tcb) begin
    if (!bus.rst_n) begin
      tx_bdr <= `UART_BDR_RST;
      tx_irq <= `UART_IRQ_RST;
      rx_bdr <= `UART_BDR_RST;
      rx_smp <= `UART_SMP_RST;
      rx_irq <= `UART_IRQ_RST;
    end else if (trn && wr) begin
      case (reg_adr)
        REG_TX_BDR: tx_bdr <= bus.wdt[`UART_RW-1:0];
        REG_TX_IRQ: tx_irq <= bus.wdt[`UART_CW-1:0];
        REG_RX_BDR: rx_bdr <= bus.wdt[`UART_RW-1:0];
        REG_RX_SMP: rx_smp <= bus.wdt[`UART_RW-1:0];
        REG_RX_IRQ: rx_irq <= bus.wdt[`UART_CW-1:0];
        default: ;  // read only or unused, write dropped
      endcase
    end
  end

  // level interrupts
  assign irq_tx = (tx_cnt < tx_irq);  // TX running low
  assign irq_rx = (rx_cnt > rx_irq);  // RX filling up

endmodule

// ==== uart_top.sv ====
// UART peripheral top level
// TCB register block, TX/RX FIFOs, serializer and deserializer
`include "uart_config.svh"

module uart_top
  import tcb_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // TCB bus
  input  logic     bus_vld,
  input  tcb_op_t  bus_op,
  input  tcb_adr_t bus_adr,
  input  tcb_dat_t bus_wdt,
  output tcb_dat_t bus_rdt,
  output logic     bus_rdy,
  // serial line
  input  logic     uart_rxd,
  output logic     uart_txd,
  // interrupts
  output logic     irq_tx,
  output logic     irq_rx
);

  logic                tx_bus_vld, tx_bus_rdy, tx_str_vld, tx_str_rdy;
  logic [`UART_DW-1:0] tx_bus_dat, tx_str_dat;
  logic                rx_bus_vld, rx_bus_rdy, rx_str_vld;
  logic [`UART_DW-1:0] rx_bus_dat, rx_str_dat;
  logic [`UART_CW-1:0] tx_cnt, rx_cnt;
  logic [`UART_RW-1:0] tx_bdr, rx_bdr, rx_smp;

  tcb_if bus (.tcb (tcb), .rst_n (rst_n));

  assign bus.vld = bus_vld;
  assign bus.op  = bus_op;
  assign bus.adr = bus_adr;
  assign bus.wdt = bus_wdt;
  assign bus_rdt = bus.rdt;
  assign bus_rdy = bus.rdy;

  uart_regs regs (
    .bus (bus.sub),
    .tx_vld (tx_bus_vld), .tx_dat (tx_bus_dat), .tx_rdy (tx_bus_rdy),
    .rx_vld (rx_bus_vld), .rx_dat (rx_bus_dat), .rx_rdy (rx_bus_rdy),
    .tx_cnt (tx_cnt), .rx_cnt (rx_cnt),
    .tx_bdr (tx_bdr), .rx_bdr (rx_bdr), .rx_smp (rx_smp),
    .irq_tx (irq_tx), .irq_rx (irq_rx)
  );

  //////////////////////////////////////////////////////////////////////////
  // TX path
  //////////////////////////////////////////////////////////////////////////

  uart_fifo tx_fifo (
    .tcb (tcb), .rst_n (rst_n),
    .sti_vld (tx_bus_vld), .sti_dat (tx_bus_dat), .sti_rdy (tx_bus_rdy),
    .sto_vld (tx_str_vld), .sto_dat (tx_str_dat), .sto_rdy (tx_str_rdy),
    .cnt (tx_cnt)
  );

  uart_ser tx_ser (
    .tcb (tcb), .rst_n (rst_n), .cfg_bdr (tx_bdr),
    .str_vld (tx_str_vld), .str_dat (tx_str_dat), .str_rdy (tx_str_rdy),
    .txd (uart_txd)
  );

  //////////////////////////////////////////////////////////////////////////
  // RX path
  //////////////////////////////////////////////////////////////////////////

  // full FIFO drops the byte, des cannot wait
  uart_fifo rx_fifo (
    .tcb (tcb), .rst_n (rst_n),
    .sti_vld (rx_str_vld), .sti_dat (rx_str_dat), .sti_rdy (),
    .sto_vld (rx_bus_vld), .sto_dat (rx_bus_dat), .sto_rdy (rx_bus_rdy),
    .cnt (rx_cnt)
  );

  uart_des rx_des (
    .tcb (tcb), .rst_n (rst_n), .cfg_bdr (rx_bdr), .cfg_smp (rx_smp),
    .rxd (uart_rxd),
    .str_vld (rx_str_vld), .str_dat (rx_str_dat)
  );

endmodule

// ==== uart_asserts.sv ====
// UART protocol checker for uart_top
// TCB stall rules, FIFO load limit and start bit length on txd
`include "uart_config.svh"

module uart_asserts
  import tcb_pkg::*, uart_pkg::*;
(
  input logic                tcb,
  input logic                rst_n,
  input logic                bus_vld,
  input tcb_op_t             bus_op,
  input tcb_adr_t            bus_adr,
  input logic                bus_rdy,
  input logic                uart_txd,
  input logic [`UART_CW-1:0] tx_cnt,
  input logic [`UART_CW-1:0] rx_cnt,
  input logic [`UART_RW-1:0] tx_bdr
);

  int                  err_cnt;  // failed checks so far
  logic                tx_wr;    // TX data write on the bus
  logic                txd_d;
  logic                in_frm;
  logic [`UART_RW+3:0] frm_cyc;  // cycle within current frame

  initial err_cnt = 0;

  assign tx_wr = bus_vld && (bus_op == TCB_WR) && (bus_adr == REG_TX_DAT);

  ////////////////////////////////////////////////////////////////////////////
  // frame tracker counting cycles from the start edge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      txd_d   <= 1'b1;
      in_frm  <= 1'b0;
      frm_cyc <= '0;
    end else begin
      txd_d <= uart_txd;
      if (!in_frm && txd_d && !uart_txd) begin
        in_frm  <= 1'b1;  // start edge seen in bit cycle 0
        frm_cyc <= 1;
      end else if (in_frm) begin
        if (frm_cyc >= 10 * (tx_bdr + 1) - 1) in_frm <= 1'b0;  // last stop cycle
        frm_cyc <= frm_cyc + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  // line idles high out of reset
  a_txd_idle: assert property (@(posedge tcb) !rst_n |=> uart_txd)
    else begin
      $error("txd not high after reset");
      err_cnt = err_cnt + 1;
    end

  // TX write stalls exactly while the TX FIFO is full
  a_rdy_full: assert property (@(posedge tcb) disable iff (!rst_n)
    tx_wr |-> (bus_rdy == (tx_cnt != `UART_FIFO_SZ)))
    else begin
      $error("bus_rdy does not follow TX FIFO full");
      err_cnt = err_cnt + 1;
    end

  // nothing else ever stalls
  a_rdy_other: assert property (@(posedge tcb) disable iff (!rst_n) !tx_wr |-> bus_rdy)
    else begin
      $error("bus_rdy low outside a TX data write");
      err_cnt = err_cnt + 1;
    end

  a_cnt_max: assert property (@(posedge tcb) disable iff (!rst_n)
    (tx_cnt <= `UART_FIFO_SZ) && (rx_cnt <= `UART_FIFO_SZ))
    else begin
      $error("FIFO load above depth");
      err_cnt = err_cnt + 1;
    end

  // start bit low for tx_bdr+1 cycles
  a_start_low: assert property (@(posedge tcb) disable iff (!rst_n)
    (in_frm && (frm_cyc <= tx_bdr)) |-> !uart_txd)
    else begin
      $error("start bit ended early");
      err_cnt = err_cnt + 1;
    end

endmodule

bind uart_top uart_asserts asserts_i (
  .tcb (tcb), .rst_n (rst_n),
  .bus_vld (bus_vld), .bus_op (bus_op), .bus_adr (bus_adr),
  .bus_rdy (bus_rdy), .uart_txd (uart_txd),
  .tx_cnt (tx_cnt), .rx_cnt (rx_cnt), .tx_bdr (tx_bdr)
);

// ==== uart_tb.sv ====
// UART peripheral testbench
// serial loopback, TCB bus tasks, register, FIFO and interrupt checks
`include "uart_config.svh"

module uart_tb
  import tcb_pkg::*, uart_pkg::*;
();

  localparam int POLL_MAX  = 4000;  // polls or cycles before a wait gives up
  localparam int STALL_MAX = 2000;  // stall cycles before a write gives up
  localparam int IDLE_RUN  = 64;    // high cycles that mean a quiet line

  logic     tcb;
  logic     rst_n;
  logic     bus_vld;
  tcb_op_t  bus_op;
  tcb_adr_t bus_adr;
  tcb_dat_t bus_wdt;
  tcb_dat_t bus_rdt;
  logic     bus_rdy;
  logic     uart_txd;
  logic     uart_rxd;
  logic     irq_tx;
  logic     irq_rx;

  integer              seed;
  tcb_dat_t            rd_val;     // data of last transfer
  logic                irq_tx_s;   // irq lines seen with it
  logic                irq_rx_s;
  int                  stalls;     // stall cycles of last transfer
  int                  tx_lvl;     // programmed irq levels
  int                  rx_lvl;
  logic [`UART_DW-1:0] exp_q[$];   // sent, not yet received
  int                  stall_log[$];

  uart_top uart_top_i (
    .tcb (tcb), .rst_n (rst_n),
    .bus_vld (bus_vld), .bus_op (bus_op), .bus_adr (bus_adr), .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt), .bus_rdy (bus_rdy),
    .uart_rxd (uart_rxd), .uart_txd (uart_txd),
    .irq_tx (irq_tx), .irq_rx (irq_rx)
  );

  // loopback, undriven line reads idle
  assign uart_rxd = (uart_txd === 1'b0) ? 1'b0 : 1'b1;

  initial begin
    tcb = 1'b0;
    forever #50 tcb = ~tcb;
  end

  // bound checker failures
  always @(negedge tcb) begin
    if (uart_top_i.asserts_i.err_cnt != 0) begin
      $display("A protocol assertion in uart_asserts failed");
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input tcb_dat_t exp, input tcb_dat_t act);
    assert (act === exp) else begin
      $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int act);
    assert ((act >= lo) && (act <= hi)) else begin
      $display("Mismatch in %s: expected %0d to %0d, actual %0d", name, lo, hi, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus access, called and returning on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_xfer(input tcb_op_t op, input tcb_adr_t adr, input tcb_dat_t wdt);
    int n;
    n = 0;
    bus_vld = 1'b1;
    bus_op  = op;
    bus_adr = adr;
    bus_wdt = wdt;
    #10;  // settle, rdy and rdt are combinational
    while (!bus_rdy) begin
      n++;
      if (n > STALL_MAX) report_timeout("bus ready");
      @(negedge tcb);
      #10;
    end
    rd_val   = bus_rdt;
    irq_tx_s = irq_tx;
    irq_rx_s = irq_rx;
    stalls   = n;
    @(posedge tcb);  // transfer
    @(negedge tcb);
    bus_vld = 1'b0;
  endtask

  task automatic bus_write(input tcb_adr_t adr, input tcb_dat_t dat);
    bus_xfer(TCB_WR, adr, dat);
  endtask

  task automatic bus_read(input tcb_adr_t adr);
    bus_xfer(TCB_RD, adr, '0);
  endtask

  // reset value, then write and readback cut to width
  task automatic check_reg(input string name, input tcb_adr_t adr,
                           input tcb_dat_t rst_val, input int width);
    tcb_dat_t mask;
    mask = (tcb_dat_t'(1) << width) - 1;
    bus_read(adr);
    check_value({name, " reset"}, rst_val, rd_val);
    bus_write(adr, 32'hDEAD_BEEF);
    bus_read(adr);
    check_value({name, " readback"}, 32'hDEAD_BEEF & mask, rd_val);
    bus_write(adr, rst_val);
  endtask

  task automatic set_baud(input tcb_dat_t bdr, input tcb_dat_t smp);
    bus_write(REG_TX_BDR, bdr);
    bus_write(REG_RX_BDR, bdr);
    bus_write(REG_RX_SMP, smp);
  endtask

  task automatic send_byte();
    logic [`UART_DW-1:0] b;
    b = $random(seed);
    exp_q.push_back(b);
    bus_write(REG_TX_DAT, b);
    stall_log.push_back(stalls);
  endtask

  // poll RX load, irq_rx checked on every poll
  task automatic wait_rx_count(input int target);
    int n;
    n = 0;
    do begin
      n++;
      if (n > POLL_MAX) report_timeout("RX FIFO load");
      bus_read(REG_RX_CNT);
      check_value("irq_rx level", tcb_dat_t'(rd_val > rx_lvl), tcb_dat_t'(irq_rx_s));
    end while (rd_val < target);
  endtask

  task automatic wait_tx_empty();
    int n;
    n = 0;
    do begin
      n++;
      if (n > POLL_MAX) report_timeout("empty TX FIFO");
      bus_read(REG_TX_CNT);
      check_value("irq_tx level", tcb_dat_t'(rd_val < tx_lvl), tcb_dat_t'(irq_tx_s));
    end while (rd_val != 0);
  endtask

  task automatic recv_byte(input string name);
    wait_rx_count(1);
    bus_read(REG_RX_DAT);
    check_value(name, exp_q.pop_front(), rd_val);
  endtask

  // stop bit over before the baud changes
  task automatic wait_line_idle();
    int run;
    int n;
    run = 0;
    n = 0;
    while (run < IDLE_RUN) begin
      n++;
      if (n > POLL_MAX) report_timeout("idle serial line");
      @(negedge tcb);
      run = uart_txd ? run + 1 : 0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed    = 2765;
    rst_n   = 1'b0;
    bus_vld = 1'b0;
    bus_op  = TCB_RD;
    bus_adr = '0;
    bus_wdt = '0;
    tx_lvl  = 0;
    rx_lvl  = 0;
    repeat (10) @(negedge tcb);
    rst_n = 1'b1;

    // config registers
    check_reg("tx_bdr", REG_TX_BDR, `UART_BDR_RST, `UART_RW);
    check_reg("tx_irq", REG_TX_IRQ, `UART_IRQ_RST, `UART_CW);
    check_reg("rx_bdr", REG_RX_BDR, `UART_BDR_RST, `UART_RW);
    check_reg("rx_smp", REG_RX_SMP, `UART_SMP_RST, `UART_RW);
    check_reg("rx_irq", REG_RX_IRQ, `UART_IRQ_RST, `UART_CW);
    bus_write(REG_TX_CNT, 32'h5);  // read only
    bus_read(REG_TX_CNT);
    check_value("tx_cnt write ignored", 0, rd_val);
    bus_write(6'h3C, 32'hFFFF_FFFF);  // unused offset
    bus_read(6'h3C);
    check_value("unused offset", 0, rd_val);

    // loopback order
    set_baud(3, 2);
    for (int i = 0; i < 5; i++) send_byte();
    for (int i = 0; i < 5; i++) recv_byte("loopback byte");
    wait_line_idle();

    // TX load at slow baud
    set_baud(15, 7);
    for (int i = 0; i < 4; i++) send_byte();
    bus_read(REG_TX_CNT);
    check_range("tx_cnt after 4 writes", 3, 4, rd_val);
    wait_tx_empty();
    for (int i = 0; i < 4; i++) recv_byte("tx_cnt test byte");
    wait_line_idle();

    // interrupt levels
    tx_lvl = 2;
    rx_lvl = 1;
    bus_write(REG_TX_IRQ, tx_lvl);
    bus_write(REG_RX_IRQ, rx_lvl);
    bus_read(REG_TX_CNT);
    check_value("irq_tx on empty", 1, irq_tx_s);
    for (int i = 0; i < 4; i++) send_byte();
    bus_read(REG_TX_CNT);
    check_range("tx_cnt at irq check", 2, 4, rd_val);
    check_value("irq_tx low at load", 0, irq_tx_s);
    wait_rx_count(2);
    check_value("irq_rx raised", 1, irq_rx_s);
    for (int i = 0; i < 4; i++) recv_byte("irq test byte");
    bus_read(REG_RX_CNT);
    check_value("rx_cnt drained", 0, rd_val);
    check_value("irq_rx cleared", 0, irq_rx_s);
    wait_tx_empty();
    wait_line_idle();
    tx_lvl = 0;
    rx_lvl = 0;
    bus_write(REG_TX_IRQ, tx_lvl);
    bus_write(REG_RX_IRQ, rx_lvl);

    // back-pressure, fastest rate the RX side can follow
    set_baud(1, 0);
    stall_log.delete();
    for (int i = 0; i < 20; i++) send_byte();
    for (int i = 0; i <= `UART_FIFO_SZ; i++) check_value("stall before full", 0, stall_log[i]);
    check_range("stall on full FIFO", 1, STALL_MAX, stall_log[`UART_FIFO_SZ + 1]);
    for (int i = 0; i < 20; i++) recv_byte("back-pressure byte");
    wait_line_idle();

    // empty RX read
    bus_read(REG_RX_DAT);
    check_value("empty rx_dat", 0, rd_val);
    bus_read(REG_RX_CNT);
    check_value("rx_cnt after empty read", 0, rd_val);

    if (uart_top_i.asserts_i.err_cnt == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== sources.f ====
+incdir+.
tcb_pkg.sv
uart_pkg.sv
tcb_if.sv
uart_fifo.sv
uart_ser.sv
uart_des.sv
uart_regs.sv
uart_top.sv
uart_asserts.sv
uart_tb.sv
